//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --assert --timing -Mdir obj_dir
TOP       = tb_parking
FILELIST  = sim.f
LOG       = sim.log

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "TEST OK" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- sim.f
src/parking_pkg.sv
src/zone_if.sv
src/gate_fsm.sv
src/zone_counter.sv
src/panel_driver.sv
src/parking_top.sv
tb/parking_assert.sv
tb/tb_parking.sv

//--- src/gate_fsm.sv
`timescale 1ns/10ps

module gate_fsm import parking_pkg::*; #(
    parameter int tick_cycles = 50_000_000
) (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    power,
    input  logic    id_strobe,
    input  id_t     id,
    input  logic    exit_req,
    input  logic    floor_sel,
    zone_if.ctrl    zones,
    output logic    result_valid,
    output result_t result,
    output logic    holding,
    output result_t hold_kind
);

    localparam int cyc_w  = (tick_cycles > 1) ? $clog2(tick_cycles) : 1;
    localparam int slot_w = $clog2(num_known_ids);

    gate_state_t state;
    logic        decide;

    // Captured request
    id_t  id_q;
    logic exit_q;
    logic floor_q;

    // Check results
    logic      id_special;
    logic      id_normal;
    logic      cls_special;
    logic      cls_normal;
    logic      was_parked;
    zone_idx_t parked_zone;

    // Registry of parked IDs
    logic [num_known_ids-1:0] parked;
    zone_idx_t                parked_at [num_known_ids];
    logic [slot_w-1:0]        slot;

    logic [cyc_w-1:0] cyc_cnt;
    logic [2:0]       tick_cnt;
    logic [2:0]       hold_len;

    // Decision
    logic      fire;
    zone_idx_t chosen_zone;
    zone_idx_t alt_zone;
    zone_idx_t pick_zone;
    result_t   verdict;
    logic      do_take;
    logic      do_rel;

    assign id_special = (id_q >= special_id_lo) && (id_q <= special_id_hi);
    assign id_normal  = (id_q >= normal_id_lo) && (id_q <= normal_id_hi);
    assign slot       = slot_w'(id_q - special_id_lo);
    assign fire       = power && (state == st_check) && decide;
    assign holding    = (state == st_hold);

    always_comb begin
        chosen_zone = floor_q ? zone_floor1 : zone_norm0;
        alt_zone    = floor_q ? zone_norm0 : zone_floor1;
        verdict     = res_wrong;
        pick_zone   = zone_special;
        do_take     = 1'b0;
        do_rel      = 1'b0;
        if (exit_q) begin
            if (was_parked) begin
                verdict   = res_exit_ok;
                pick_zone = parked_zone;
                do_rel    = 1'b1;
            end
        end else if ((cls_special || cls_normal) && !was_parked) begin
            if (cls_special) begin
                if (!zones.full[zone_special]) begin
                    verdict = res_granted_chosen;
                    do_take = 1'b1;
                end else begin
                    verdict = res_no_space;
                end
            end else if (!zones.full[chosen_zone]) begin
                verdict   = res_granted_chosen;
                pick_zone = chosen_zone;
                do_take   = 1'b1;
            end else if (!zones.full[alt_zone]) begin
                verdict   = res_granted_alt;
                pick_zone = alt_zone;
                do_take   = 1'b1;
            end else begin
                verdict = res_no_space;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= st_off;
            decide       <= 1'b0;
            result_valid <= 1'b0;
            zones.take   <= '0;
            zones.rel    <= '0;
            parked       <= '0;
            cyc_cnt      <= '0;
            tick_cnt     <= '0;
            hold_len     <= hold_ticks_short;
        end else begin
            result_valid <= 1'b0;
            zones.take   <= '0;
            zones.rel    <= '0;
            if (!power) begin
                state  <= st_off;
                decide <= 1'b0;
            end else begin
                case (state)
                    st_off: begin
                        state <= st_idle;
                    end
                    st_idle: begin
                        decide <= 1'b0;
                        if (id_strobe) begin
                            state <= st_check;
                        end
                    end
                    st_check: begin
                        if (!decide) begin
                            decide <= 1'b1;
                        end else begin
                            result_valid          <= 1'b1;
                            zones.take[pick_zone] <= do_take;
                            zones.rel[pick_zone]  <= do_rel;
                            if (do_take) begin
                                parked[slot] <= 1'b1;
                            end
                            if (do_rel) begin
                                parked[slot] <= 1'b0;
                            end
                            // Timer restarts here
                            cyc_cnt  <= '0;
                            tick_cnt <= '0;
                            hold_len <= (verdict == res_wrong) ? hold_ticks_long
                                                               : hold_ticks_short;
                            state    <= st_hold;
                        end
                    end
                    st_hold: begin
                        if (cyc_cnt == cyc_w'(tick_cycles - 1)) begin
                            cyc_cnt <= '0;
                            if (tick_cnt == hold_len - 3'd1) begin
                                state <= st_idle;
                            end else begin
                                tick_cnt <= tick_cnt + 3'd1;
                            end
                        end else begin
                            cyc_cnt <= cyc_cnt + 1'b1;
                        end
                    end
                    default: begin
                        state <= st_off;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (power && (state == st_idle) && id_strobe) begin
            id_q    <= id;
            exit_q  <= exit_req;
            floor_q <= floor_sel;
        end
        if (power && (state == st_check) && !decide) begin
            cls_special <= id_special;
            cls_normal  <= id_normal;
            was_parked  <= (id_special || id_normal) && parked[slot];
            parked_zone <= parked_at[slot];
        end
        if (fire) begin
            result    <= verdict;
            hold_kind <= verdict;
            if (do_take) begin
                parked_at[slot] <= pick_zone;
            end
        end
    end

endmodule

//--- src/panel_driver.sv
`timescale 1ns/10ps

module panel_driver import parking_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    power,
    input  logic    holding,
    input  result_t hold_kind,
    zone_if.view    zones,
    output logic    power_led,
    output logic    green_led,
    output logic    wrong_led,
    output seg_t    seg_special,
    output seg_t    seg_norm0,
    output seg_t    seg_floor1
);

    logic show_green;
    logic show_wrong;

    // Decimal digit to segments a..g
    function automatic seg_t digit_seg(input count_t d);
        case (d)
            3'd0:    digit_seg = 7'h3F;
            3'd1:    digit_seg = 7'h06;
            3'd2:    digit_seg = 7'h5B;
            3'd3:    digit_seg = 7'h4F;
            3'd4:    digit_seg = 7'h66;
            3'd5:    digit_seg = 7'h6D;
            3'd6:    digit_seg = 7'h7D;
            default: digit_seg = 7'h07;
        endcase
    endfunction

    assign show_green = (hold_kind == res_granted_chosen) || (hold_kind == res_granted_alt)
                     || (hold_kind == res_exit_ok);
    assign show_wrong = (hold_kind == res_wrong) || (hold_kind == res_no_space);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            power_led <= 1'b0;
            green_led <= 1'b0;
            wrong_led <= 1'b0;
        end else begin
            power_led <= power;
            green_led <= holding && show_green;
            wrong_led <= holding && show_wrong;
        end
    end

    always_ff @(posedge clk) begin
        seg_special <= digit_seg(zones.free_count[zone_special]);
        seg_norm0   <= digit_seg(zones.free_count[zone_norm0]);
        seg_floor1  <= digit_seg(zones.free_count[zone_floor1]);
    end

endmodule

//--- src/parking_pkg.sv
package parking_pkg;

    // Driver ID and its known ranges
    typedef logic [7:0] id_t;

    localparam id_t special_id_lo = 8'h10;
    localparam id_t special_id_hi = 8'h1F;
    localparam id_t normal_id_lo  = 8'h20;
    localparam id_t normal_id_hi  = 8'h3F;

    // Registry covers every known ID
    localparam int num_known_ids = 48;

    // Zones
    typedef logic [1:0] zone_idx_t;

    localparam int        num_zones    = 3;
    localparam zone_idx_t zone_special = 2'd0;
    localparam zone_idx_t zone_norm0   = 2'd1;
    localparam zone_idx_t zone_floor1  = 2'd2;

    // Free spaces of one zone, 0 to 7
    typedef logic [2:0] count_t;

    // Seven-segment pattern, bit 0 is segment a
    typedef logic [6:0] seg_t;

    typedef enum logic [2:0] {
        res_granted_chosen,
        res_granted_alt,
        res_no_space,
        res_wrong,
        res_exit_ok
    } result_t;

    typedef enum logic [2:0] {
        st_off,
        st_idle,
        st_check,
        st_hold
    } gate_state_t;

    // Hold lengths in ticks
    localparam logic [2:0] hold_ticks_short = 3'd3;
    localparam logic [2:0] hold_ticks_long  = 3'd5;

endpackage

//--- src/parking_top.sv
`timescale 1ns/10ps

module parking_top import parking_pkg::*; #(
    parameter int tick_cycles = 50_000_000,
    parameter int cap_special = 2,
    parameter int cap_norm0   = 3,
    parameter int cap_floor1  = 5
) (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    power,
    input  logic    id_strobe,
    input  id_t     id,
    input  logic    exit_req,
    input  logic    floor_sel,
    output logic    result_valid,
    output result_t result,
    output logic    power_led,
    output logic    green_led,
    output logic    wrong_led,
    output seg_t    seg_special,
    output seg_t    seg_norm0,
    output seg_t    seg_floor1
);

    logic    holding;
    result_t hold_kind;

    zone_if zones ();

    gate_fsm #(
        .tick_cycles (tick_cycles)
    ) u_gate_fsm (
        .clk          (clk),
        .rst_n        (rst_n),
        .power        (power),
        .id_strobe    (id_strobe),
        .id           (id),
        .exit_req     (exit_req),
        .floor_sel    (floor_sel),
        .zones        (zones.ctrl),
        .result_valid (result_valid),
        .result       (result),
        .holding      (holding),
        .hold_kind    (hold_kind)
    );

    for (genvar i = 0; i < num_zones; i++) begin : g_zone
        zone_counter #(
            .cap (i == zone_special ? count_t'(cap_special) :
                  i == zone_norm0   ? count_t'(cap_norm0) : count_t'(cap_floor1)),
            .idx (zone_idx_t'(i))
        ) u_zone_counter (
            .clk   (clk),
            .rst_n (rst_n),
            .port  (zones.zone)
        );
    end

    panel_driver u_panel_driver (
        .clk         (clk),
        .rst_n       (rst_n),
        .power       (power),
        .holding     (holding),
        .hold_kind   (hold_kind),
        .zones       (zones.view),
        .power_led   (power_led),
        .green_led   (green_led),
        .wrong_led   (wrong_led),
        .seg_special (seg_special),
        .seg_norm0   (seg_norm0),
        .seg_floor1  (seg_floor1)
    );

endmodule

//--- src/zone_counter.sv
`timescale 1ns/10ps

module zone_counter import parking_pkg::*; #(
    parameter count_t    cap = 3'd2,
    parameter zone_idx_t idx = zone_special
) (
    input logic  clk,
    input logic  rst_n,
    zone_if.zone port
);

    count_t cnt;

    // Saturates at empty and at capacity
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= cap;
        end else if (port.take[idx]) begin
            if (cnt != '0) begin
                cnt <= cnt - 3'd1;
            end
        end else if (port.rel[idx]) begin
            if (cnt != cap) begin
                cnt <= cnt + 3'd1;
            end
        end
    end

    assign port.free_count[idx] = cnt;
    assign port.full[idx]       = (cnt == '0);

endmodule

//--- src/zone_if.sv
`timescale 1ns/10ps

interface zone_if import parking_pkg::*; ();

    // One pulse per zone from the gate controller
    logic [num_zones-1:0] take;
    logic [num_zones-1:0] rel;

    // Per-zone state from the counters
    logic   full [num_zones];
    count_t free_count [num_zones];

    modport ctrl (
        output take,
        output rel,
        input  full
    );

    modport zone (
        input  take,
        input  rel,
        output full,
        output free_count
    );

    modport view (
        input free_count
    );

endinterface

//--- tb/parking_assert.sv
`timescale 1ns/10ps

module parking_assert import parking_pkg::*; (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 result_valid,
    input logic                 green_led,
    input logic                 wrong_led,
    input logic [num_zones-1:0] take,
    input logic [num_zones-1:0] rel,
    input logic [num_zones-1:0] full
);

    int fail_count = 0;

    a_valid_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        result_valid |=> !result_valid)
        else begin
            fail_count++;
            $error("result_valid longer than one cycle");
        end

    a_take_rel: assert property (@(posedge clk) disable iff (!rst_n)
        !((|take) && (|rel)))
        else begin
            fail_count++;
            $error("take and release together");
        end

    a_lamps: assert property (@(posedge clk) disable iff (!rst_n)
        !(green_led && wrong_led))
        else begin
            fail_count++;
            $error("green and wrong lamps together");
        end

    // Counter state is still the pre-take value in the pulse cycle
    a_take_full: assert property (@(posedge clk) disable iff (!rst_n)
        (take & full) == '0)
        else begin
            fail_count++;
            $error("take issued to a full zone");
        end

endmodule

bind parking_top parking_assert u_parking_assert (
    .clk          (clk),
    .rst_n        (rst_n),
    .result_valid (result_valid),
    .green_led    (green_led),
    .wrong_led    (wrong_led),
    .take         (zones.take),
    .rel          (zones.rel),
    .full         ({zones.full[2], zones.full[1], zones.full[0]})
);

//--- tb/tb_parking.sv
`timescale 1ns/10ps

module tb_parking;
    import parking_pkg::*;

    localparam int clk_period  = 40;
    localparam int tick_cycles = 20;
    localparam int hold_limit  = 8 * tick_cycles;

    logic    clk;
    logic    rst_n;
    logic    power;
    logic    id_strobe;
    id_t     id;
    logic    exit_req;
    logic    floor_sel;
    logic    result_valid;
    result_t result;
    logic    power_led;
    logic    green_led;
    logic    wrong_led;
    seg_t    seg_special;
    seg_t    seg_norm0;
    seg_t    seg_floor1;

    // Reference model state
    count_t    free_cnt [num_zones];
    logic      in_lot [num_known_ids];
    zone_idx_t lot_zone [num_known_ids];
    logic [31:0] lfsr;

    parking_top #(
        .tick_cycles (tick_cycles)
    ) UUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .power        (power),
        .id_strobe    (id_strobe),
        .id           (id),
        .exit_req     (exit_req),
        .floor_sel    (floor_sel),
        .result_valid (result_valid),
        .result       (result),
        .power_led    (power_led),
        .green_led    (green_led),
        .wrong_led    (wrong_led),
        .seg_special  (seg_special),
        .seg_norm0    (seg_norm0),
        .seg_floor1   (seg_floor1)
    );

    always #(clk_period / 2) clk = ~clk;

    function automatic logic next_bit();
        logic b;
        b = lfsr[0];
        lfsr = lfsr >> 1;
        if (b) begin
            lfsr = lfsr ^ 32'h8020_0003;
        end
        return b;
    endfunction

    function automatic logic [7:0] rand_bits(input int n);
        logic [7:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[6:0], next_bit()};
        end
        return r;
    endfunction

    // Segments a..g for decimal digits
    function automatic seg_t seg_of(input count_t n);
        seg_t table_seg [8];
        table_seg = '{7'h3F, 7'h06, 7'h5B, 7'h4F, 7'h66, 7'h6D, 7'h7D, 7'h07};
        return table_seg[n];
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_result(input string name, input result_t got, input result_t exp);
        if (got !== exp) begin
            $display("error %s got %h expected %h", name, got, exp);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    task automatic check_count(input string name, input seg_t got, input seg_t exp);
        if (got !== exp) begin
            $display("error %s got %h expected %h", name, got, exp);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    task automatic check_lamp(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("error %s got %h expected %h", name, got, exp);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    // Applies one request to the model and returns the expected result
    task automatic model_step(input id_t rid, input logic ex, input logic fl,
                              output result_t exp);
        logic      spec;
        logic      norm;
        int        k;
        zone_idx_t ch;
        zone_idx_t alt;
        spec = (rid >= 8'h10) && (rid <= 8'h1F);
        norm = (rid >= 8'h20) && (rid <= 8'h3F);
        k    = int'(rid) - 16;
        ch   = fl ? 2'd2 : 2'd1;
        alt  = fl ? 2'd1 : 2'd2;
        exp  = res_wrong;
        if (!(spec || norm)) begin
            exp = res_wrong;
        end else if (ex) begin
            if (in_lot[k]) begin
                exp = res_exit_ok;
                in_lot[k] = 1'b0;
                free_cnt[lot_zone[k]] = free_cnt[lot_zone[k]] + 3'd1;
            end
        end else if (!in_lot[k]) begin
            if (spec) begin
                if (free_cnt[0] != 3'd0) begin
                    exp = res_granted_chosen;
                    lot_zone[k] = 2'd0;
                end else begin
                    exp = res_no_space;
                end
            end else if (free_cnt[ch] != 3'd0) begin
                exp = res_granted_chosen;
                lot_zone[k] = ch;
            end else if (free_cnt[alt] != 3'd0) begin
                exp = res_granted_alt;
                lot_zone[k] = alt;
            end else begin
                exp = res_no_space;
            end
            if (exp == res_granted_chosen || exp == res_granted_alt) begin
                in_lot[k] = 1'b1;
                free_cnt[lot_zone[k]] = free_cnt[lot_zone[k]] - 3'd1;
            end
        end
    endtask

    task automatic check_segments();
        check_count("seg_special", seg_special, seg_of(free_cnt[0]));
        check_count("seg_norm0", seg_norm0, seg_of(free_cnt[1]));
        check_count("seg_floor1", seg_floor1, seg_of(free_cnt[2]));
    endtask

    // One full decision; poke adds a strobe during the hold that must be dropped
    task automatic run_request(input id_t rid, input logic ex, input logic fl,
                               input logic poke);
        result_t exp;
        int      waited;
        logic    grn;
        time     t_on;
        int      hold_cyc;
        model_step(rid, ex, fl, exp);
        @(posedge clk);
        id_strobe <= 1'b1;
        id        <= rid;
        exit_req  <= ex;
        floor_sel <= fl;
        @(posedge clk);
        id_strobe <= 1'b0;
        waited = 0;
        forever begin
            @(negedge clk);
            if (result_valid) break;
            waited++;
            if (waited > 10) fail_run("timeout waiting for result_valid");
        end
        if (waited != 2) fail_run("result arrived at the wrong cycle");
        check_result("result", result, exp);
        grn = (exp == res_granted_chosen) || (exp == res_granted_alt) || (exp == res_exit_ok);
        @(negedge clk);
        check_lamp("green_led", green_led, grn);
        check_lamp("wrong_led", wrong_led, !grn);
        t_on = $time;
        @(negedge clk);
        check_segments();
        if (poke) begin
            @(posedge clk);
            id_strobe <= 1'b1;
            id        <= rand_bits(8);
            @(posedge clk);
            id_strobe <= 1'b0;
        end
        waited = 0;
        while (green_led || wrong_led) begin
            @(negedge clk);
            check_lamp("result_valid", result_valid, 1'b0);
            waited++;
            if (waited > hold_limit) fail_run("timeout waiting for the end of the hold");
        end
        // Wrong holds for 5 ticks, all other results for 3
        hold_cyc = int'(($time - t_on) / clk_period);
        if (hold_cyc != ((exp == res_wrong) ? 5 : 3) * tick_cycles) begin
            fail_run("lamps held for the wrong number of cycles");
        end
    endtask

    task automatic wait_power_led(input logic level);
        int waited;
        waited = 0;
        while (power_led !== level) begin
            @(negedge clk);
            waited++;
            if (waited > 10) fail_run("power_led did not follow power");
        end
    endtask

    // Power off, a strobe that must be dropped, power back on
    task automatic power_cycle();
        @(posedge clk);
        power <= 1'b0;
        wait_power_led(1'b0);
        @(posedge clk);
        id_strobe <= 1'b1;
        id        <= 8'h25;
        @(posedge clk);
        id_strobe <= 1'b0;
        repeat (6) begin
            @(negedge clk);
            check_lamp("result_valid", result_valid, 1'b0);
        end
        @(posedge clk);
        power <= 1'b1;
        wait_power_led(1'b1);
        check_segments();
    endtask

    initial begin
        id_t       rid;
        logic      ex;
        logic      fl;
        logic [7:0] pick;
        clk       = 1'b0;
        rst_n     = 1'b0;
        power     = 1'b0;
        id_strobe = 1'b0;
        id        = '0;
        exit_req  = 1'b0;
        floor_sel = 1'b0;
        lfsr      = 32'hc8a1f3a5;
        free_cnt  = '{3'd2, 3'd3, 3'd5};
        for (int i = 0; i < num_known_ids; i++) begin
            in_lot[i]   = 1'b0;
            lot_zone[i] = 2'd0;
        end
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_lamp("power_led", power_led, 1'b0);
        check_lamp("green_led", green_led, 1'b0);
        check_lamp("wrong_led", wrong_led, 1'b0);
        check_lamp("result_valid", result_valid, 1'b0);
        check_segments();
        @(posedge clk);
        power <= 1'b1;
        wait_power_led(1'b1);

        // Normal floor 0 fills, then overflows to floor 1
        for (int i = 0; i < 4; i++) begin
            run_request(id_t'(8'h20 + i), 1'b0, 1'b0, 1'b0);
        end
        for (int i = 4; i < 9; i++) begin
            run_request(id_t'(8'h20 + i), 1'b0, 1'b1, 1'b0);
        end
        // Special zone, then the wrong cases
        run_request(8'h10, 1'b0, 1'b0, 1'b0);
        run_request(8'h11, 1'b0, 1'b1, 1'b0);
        run_request(8'h12, 1'b0, 1'b0, 1'b0);
        run_request(8'h05, 1'b0, 1'b0, 1'b0);
        run_request(8'h80, 1'b0, 1'b0, 1'b0);
        run_request(8'h20, 1'b0, 1'b0, 1'b0);
        run_request(8'h30, 1'b1, 1'b0, 1'b0);
        // Exits free the ID's own zone
        run_request(8'h23, 1'b1, 1'b0, 1'b0);
        run_request(8'h10, 1'b1, 1'b1, 1'b1);
        run_request(8'h21, 1'b1, 1'b1, 1'b0);
        power_cycle();

        for (int n = 0; n < 400; n++) begin
            pick = rand_bits(3);
            if (pick == 8'd0) begin
                rid = rand_bits(8);
            end else begin
                rid = id_t'(8'h10 + (rand_bits(6) % 8'd48));
            end
            ex = next_bit();
            fl = next_bit();
            run_request(rid, ex, fl, next_bit() & next_bit());
            if (rand_bits(5) == 8'h1F) begin
                power_cycle();
            end
        end
        if (UUT.u_parking_assert.fail_count != 0) begin
            fail_run("a bound assertion failed during the run");
        end else begin
            $display("TEST OK");
            $finish;
        end
    end

    initial begin
        #(clk_period * 200000);
        $display("simulation time limit reached");
        $display("TEST FAILED");
        $fatal(1);
    end

endmodule
